//--- common/lt_eq_cfg.svh
// ====================================================================
// sink register map and training limits for channel equalization
// ====================================================================
`ifndef LT_EQ_CFG_SVH
`define LT_EQ_CFG_SVH

// sink addresses
`define LT_ADDR_TPS     20'h00102   // training pattern select, adjust bytes follow
`define LT_ADDR_ADJ     20'h00103   // lane 0 adjust byte
`define LT_ADDR_STATUS  20'h00202   // lane status block

// status read length code
`define LT_STATUS_LEN   8'd5

// failed eq checks before fall-back
`define LT_MAX_LOOPS    3'd6

// first payload byte of the 0x102 write per pattern
`define LT_TPS2_CODE    8'h22
`define LT_TPS3_CODE    8'h23
`define LT_TPS4_CODE    8'h07

// payload capacity of one aux request
`define LT_MSG_BYTES    5

`endif

//--- common/lt_eq_pkg.sv
// ====================================================================
// types shared by the eq trainer, payload width follows LT_MSG_BYTES
// ====================================================================
`include "lt_eq_cfg.svh"

package lt_eq_pkg;

    typedef enum logic [3:0] {
        IDLE      = 4'd0,
        TPS       = 4'd1,
        WAIT      = 4'd2,
        READ_ADJ  = 4'd3,
        CHK_CR    = 4'd4,
        CHK_EQ    = 4'd5,
        WRITE_ADJ = 4'd6,
        PASS      = 4'd7,
        FAIL      = 4'd8
    } lt_state_e;

    typedef enum logic [1:0] {AUX_WRITE = 2'd0, AUX_READ = 2'd1} aux_cmd_e;

    // code doubles as the phy pattern instruction
    typedef enum logic [1:0] {TPS_NONE = 2'd0, TPS2 = 2'd1, TPS3 = 2'd2, TPS4 = 2'd3} tps_e;

    typedef enum logic [1:0] {LC_1 = 2'd0, LC_2 = 2'd1, LC_4 = 2'd3} lane_cnt_e;

    typedef struct packed {
        logic [7:0] bw;
        lane_cnt_e  lc;
    } link_cfg_t;

    typedef struct packed {
        tps_e       tps;
        logic [1:0] max_vtg;
        logic [1:0] max_pre;
    } sink_limits_t;

    typedef struct packed {
        logic [3:0] cr_done;
        logic [3:0] chan_eq;
        logic [3:0] sym_lock;
        logic [7:0] lane_align;
        logic [7:0] vtg;        // 2 bits per lane, lane 0 low
        logic [7:0] pre;
    } sink_status_t;

    typedef struct packed {
        logic [19:0]                 addr;
        logic [7:0]                  len;
        aux_cmd_e                    cmd;
        logic [`LT_MSG_BYTES*8-1:0] payload;  // first byte in the top bits
        logic [2:0]                  nbytes;
    } aux_req_t;

endpackage

//--- compile.f
+incdir+common
common/lt_eq_pkg.sv
logic/adj_capture.sv
eq_fsm/eq_fsm.sv
logic/aux_msg_shifter.sv
logic/lt_eq_top.sv
test/tb_lt_eq.sv

//--- eq_fsm/eq_fsm.sv
`timescale 1ns/1ns
`include "lt_eq_cfg.svh"
// ====================================================================
// each request state waits for ack or native failed with no timeout
// ====================================================================
module eq_fsm (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 eq_start,
    input  logic                 err_chk_failed,
    input  logic                 ctr_fire,
    input  logic                 ctrl_ack,
    input  logic                 ctrl_native_failed,
    input  lt_eq_pkg::tps_e      tps,
    input  lt_eq_pkg::link_cfg_t link,
    input  logic [3:0][7:0]      adj_bytes,
    input  logic [3:0]           cr_status,
    input  logic                 status_saved,
    input  logic                 cr_ok,
    input  logic                 eq_ok,
    output logic                 clr_saved,
    output logic                 req_load,
    output lt_eq_pkg::aux_req_t  req,
    output lt_eq_pkg::tps_e      phy_instruct,
    output logic                 phy_instruct_vld,
    output logic                 ctr_start,
    output logic                 cr_failed,
    output logic                 start_cr_err,
    output logic                 start_eq_err,
    output logic [3:0]           err_cr_dn,
    output logic                 lt_pass,
    output logic                 lt_fail,
    output lt_eq_pkg::link_cfg_t final_link,
    output lt_eq_pkg::link_cfg_t adj_link
);
    import lt_eq_pkg::*;

    lt_state_e  state;
    lt_state_e  next_state;
    logic [2:0] loop_cnt;     // failed eq checks so far
    logic [2:0] n_lanes;
    logic [7:0] tps_code;
    logic       enter_req;
    logic       cr_fall;
    logic       eq_fall;

    assign cr_fall   = (state == CHK_CR) && status_saved && !cr_ok;
    assign eq_fall   = (state == CHK_EQ) && status_saved && !eq_ok &&
                       (loop_cnt == `LT_MAX_LOOPS - 3'd1);
    assign enter_req = (next_state != state) &&
                       (next_state inside {TPS, READ_ADJ, WRITE_ADJ, PASS, FAIL});
    assign clr_saved = (next_state == WAIT) && (state != WAIT);

    // ================================================================
    // next state
    // ================================================================
    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
            begin
                if (eq_start)
                    next_state = TPS;
                else if (err_chk_failed)
                    next_state = FAIL;
            end
            TPS, WRITE_ADJ:
            begin
                if (ctrl_ack)
                    next_state = WAIT;
                else if (ctrl_native_failed)
                    next_state = IDLE;
            end
            WAIT:     if (ctr_fire) next_state = READ_ADJ;
            READ_ADJ:
            begin
                if (ctrl_ack)
                    next_state = CHK_CR;
                else if (ctrl_native_failed)
                    next_state = IDLE;
            end
            CHK_CR:   if (status_saved) next_state = cr_ok ? CHK_EQ : IDLE;
            CHK_EQ:
            begin
                if (status_saved)
                    next_state = eq_ok ? PASS : (eq_fall ? IDLE : WRITE_ADJ);
            end
            PASS, FAIL: if (ctrl_ack || ctrl_native_failed) next_state = IDLE;
            default:  next_state = IDLE;
        endcase
    end

    // ================================================================
    // request building
    // ================================================================
    always_comb
    begin
        case (link.lc)
            LC_1:    n_lanes = 3'd1;
            LC_2:    n_lanes = 3'd2;
            default: n_lanes = 3'd4;
        endcase
        case (tps)
            TPS2:    tps_code = `LT_TPS2_CODE;
            TPS3:    tps_code = `LT_TPS3_CODE;
            TPS4:    tps_code = `LT_TPS4_CODE;
            default: tps_code = 8'h00;
        endcase
    end

    // fields follow the current state, the shifter takes them on req_load
    always_comb
    begin
        req        = '0;              // one zero byte written to 0x102
        req.addr   = `LT_ADDR_TPS;
        req.nbytes = 3'd1;
        case (state)
            TPS:
            begin
                req.len     = {5'd0, n_lanes};
                req.payload = {tps_code, adj_bytes[0], adj_bytes[1], adj_bytes[2],
                               adj_bytes[3]};
                req.nbytes  = n_lanes + 3'd1;
            end
            READ_ADJ:
            begin
                req.addr = `LT_ADDR_STATUS;
                req.len  = `LT_STATUS_LEN;
                req.cmd  = AUX_READ;
            end
            WRITE_ADJ:
            begin
                req.addr    = `LT_ADDR_ADJ;
                req.len     = {5'd0, n_lanes - 3'd1};
                req.payload = {adj_bytes[0], adj_bytes[1], adj_bytes[2], adj_bytes[3],
                               8'h00};
                req.nbytes  = n_lanes;
            end
            default: ;
        endcase
    end

    // ================================================================
    // state, loop count and registered outputs
    // ================================================================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state            <= IDLE;
            loop_cnt         <= 3'd0;
            req_load         <= 1'b0;
            phy_instruct     <= TPS_NONE;
            phy_instruct_vld <= 1'b0;
            adj_link         <= '0;
            ctr_start        <= 1'b0;
            cr_failed        <= 1'b0;
            start_cr_err     <= 1'b0;
            start_eq_err     <= 1'b0;
            err_cr_dn        <= 4'd0;
            lt_pass          <= 1'b0;
            lt_fail          <= 1'b0;
            final_link       <= '0;
        end
        else
        begin
            state <= next_state;
            if (state == TPS)
                loop_cnt <= 3'd0;
            else if ((state == CHK_EQ) && status_saved && !eq_ok)
                loop_cnt <= loop_cnt + 3'd1;
            req_load         <= enter_req;
            phy_instruct_vld <= (state == TPS);
            phy_instruct     <= (state == TPS) ? tps : TPS_NONE;
            adj_link         <= (state == TPS) ? link : '0;
            ctr_start        <= (state == WAIT) && (next_state == WAIT);
            cr_failed        <= cr_fall || eq_fall;   // policy maker restarts cr
            start_cr_err     <= cr_fall;
            start_eq_err     <= eq_fall;
            err_cr_dn        <= cr_fall ? cr_status : 4'd0;
            lt_pass          <= req_load && (state == PASS);
            lt_fail          <= req_load && (state == FAIL);
            if (req_load && (state == PASS))
                final_link <= link;
        end
    end

    a_load_single: assert property (@(posedge clk) disable iff (!rst_n)
        req_load |=> !req_load);
    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state inside {IDLE, TPS, WAIT, READ_ADJ, CHK_CR, CHK_EQ, WRITE_ADJ, PASS, FAIL});

endmodule

//--- logic/adj_capture.sv
`timescale 1ns/1ns
// ====================================================================
// adjust bytes follow the later of eq_start and the last status read
// lane count code 2 is invalid and never reports done
// ====================================================================
module adj_capture (
    input  logic                    clk,
    input  logic                    rst_n,
    input  lt_eq_pkg::sink_limits_t limits,
    input  logic                    limits_vld,
    input  logic                    eq_start,
    input  lt_eq_pkg::link_cfg_t    new_link,
    input  logic [7:0]              new_vtg,
    input  logic [7:0]              new_pre,
    input  lt_eq_pkg::sink_status_t status,
    input  logic                    status_vld,
    input  logic                    clr_saved,
    output lt_eq_pkg::tps_e         tps,
    output lt_eq_pkg::link_cfg_t    link,
    output logic [3:0][7:0]         adj_bytes,
    output logic [3:0]              cr_status,
    output logic                    status_saved,
    output logic                    cr_ok,
    output logic                    eq_ok
);
    import lt_eq_pkg::*;

    sink_limits_t limits_q;
    sink_status_t status_q;
    logic [3:0]   lane_mask;

    // {00, pre at max, pre, vtg at max, vtg}
    function automatic logic [7:0] adj_byte(input logic [1:0] vtg, input logic [1:0] pre,
                                            input logic [1:0] max_vtg,
                                            input logic [1:0] max_pre);
        return {2'b00, pre == max_pre, pre, vtg == max_vtg, vtg};
    endfunction

    // ================================================================
    // limits, requested link and status flag
    // ================================================================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            limits_q     <= '0;
            link         <= '0;
            status_saved <= 1'b0;
        end
        else
        begin
            if (limits_vld)
                limits_q <= limits;
            if (eq_start)
                link <= new_link;
            if (clr_saved)
                status_saved <= 1'b0;     // new wait interval
            else if (status_vld)
                status_saved <= 1'b1;
        end
    end

    // adjust bytes and status copy
    always_ff @(posedge clk)
    begin
        if (eq_start)
        begin
            for (int i = 0; i < 4; i++)
                adj_bytes[i] <= adj_byte(new_vtg[2*i +: 2], new_pre[2*i +: 2],
                                         limits_q.max_vtg, limits_q.max_pre);
        end
        else if (status_vld)
        begin
            for (int i = 0; i < 4; i++)
                adj_bytes[i] <= adj_byte(status.vtg[2*i +: 2], status.pre[2*i +: 2],
                                         limits_q.max_vtg, limits_q.max_pre);
            status_q <= status;
        end
    end

    // ================================================================
    // done decode for the active lanes
    // ================================================================
    always_comb
    begin
        case (link.lc)
            LC_1:    lane_mask = 4'b0001;
            LC_2:    lane_mask = 4'b0011;
            LC_4:    lane_mask = 4'b1111;
            default: lane_mask = 4'b0000;
        endcase
    end

    assign tps       = limits_q.tps;
    assign cr_status = status_q.cr_done;
    assign cr_ok     = status_saved && (lane_mask != 4'b0000) &&
                       ((status_q.cr_done & lane_mask) == lane_mask);
    assign eq_ok     = cr_ok && ((status_q.chan_eq & lane_mask) == lane_mask) &&
                       ((status_q.sym_lock & lane_mask) == lane_mask) &&
                       (status_q.lane_align == 8'hFF);

endmodule

//--- logic/aux_msg_shifter.sv
`timescale 1ns/1ns
`include "lt_eq_cfg.svh"
// ====================================================================
// a new load must wait until the previous burst has drained
// ====================================================================
module aux_msg_shifter (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_load,
    input  lt_eq_pkg::aux_req_t req,
    output logic [7:0]          aux_data,
    output logic                aux_vld,
    output logic [19:0]         aux_addr,
    output logic [7:0]          aux_len,
    output lt_eq_pkg::aux_cmd_e aux_cmd
);

    logic [`LT_MSG_BYTES*8-1:0] shift_q;
    logic [2:0]                  left_q;    // bytes still to send

    // ================================================================
    // byte count
    // ================================================================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            left_q <= 3'd0;
        else if (req_load)
            left_q <= req.nbytes;
        else if (left_q != 3'd0)
            left_q <= left_q - 3'd1;
    end

    // ================================================================
    // payload and header fields
    // ================================================================
    always_ff @(posedge clk)
    begin
        if (req_load)
        begin
            shift_q  <= req.payload;
            aux_addr <= req.addr;   // held through the burst
            aux_len  <= req.len;
            aux_cmd  <= req.cmd;
        end
        else if (aux_vld)
        begin
            shift_q <= {shift_q[`LT_MSG_BYTES*8-9:0], 8'h00};
        end
    end

    assign aux_vld  = (left_q != 3'd0);
    assign aux_data = shift_q[`LT_MSG_BYTES*8-1 -: 8];   // top byte goes first

    a_no_load_mid_burst: assert property (@(posedge clk) disable iff (!rst_n)
        req_load |-> !aux_vld);

endmodule

//--- logic/lt_eq_top.sv
`timescale 1ns/1ns
// ====================================================================
// limits_vld must precede eq_start for the adjust bytes to be valid
// ====================================================================
module lt_eq_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  lt_eq_pkg::sink_limits_t limits,
    input  logic                    limits_vld,
    input  logic                    eq_start,
    input  lt_eq_pkg::link_cfg_t    new_link,
    input  logic [7:0]              new_vtg,
    input  logic [7:0]              new_pre,
    input  lt_eq_pkg::sink_status_t status,
    input  logic                    status_vld,
    input  logic                    ctrl_ack,
    input  logic                    ctrl_native_failed,
    input  logic                    err_chk_failed,
    input  logic                    ctr_fire,
    output logic [7:0]              aux_data,
    output logic                    aux_vld,
    output logic [19:0]             aux_addr,
    output logic [7:0]              aux_len,
    output lt_eq_pkg::aux_cmd_e     aux_cmd,
    output lt_eq_pkg::tps_e         phy_instruct,
    output logic                    phy_instruct_vld,
    output logic                    ctr_start,
    output logic                    cr_failed,
    output logic                    start_cr_err,
    output logic                    start_eq_err,
    output logic [3:0]              err_cr_dn,
    output logic                    lt_pass,
    output logic                    lt_fail,
    output lt_eq_pkg::link_cfg_t    final_link,
    output lt_eq_pkg::link_cfg_t    adj_link
);
    import lt_eq_pkg::*;

    tps_e            tps;
    link_cfg_t       link;
    logic [3:0][7:0] adj_bytes;    // lane 0 at index 0
    logic [3:0]      cr_status;
    logic            status_saved;
    logic            cr_ok;
    logic            eq_ok;
    logic            clr_saved;
    logic            req_load;
    aux_req_t        req;

    adj_capture u_adj_capture (.*);

    eq_fsm u_eq_fsm (.*);

    aux_msg_shifter u_aux_msg_shifter (.*);

endmodule

//--- test/tb_lt_eq.sv
`timescale 1ns/1ns
`include "lt_eq_cfg.svh"
// ======================================================================
// random trainings against a sink model; each eq_start is first aborted
// with native failed, then the training is started again
// ======================================================================
module tb_lt_eq;
    import lt_eq_pkg::*;

    localparam int NUM_TRAININGS = 40;
    localparam int CYCLE_LIMIT   = NUM_TRAININGS * 8 * 40;   // trainings x loops x cycles

    logic         clk = 1'b0;
    logic         rst_n;
    sink_limits_t limits;
    link_cfg_t    new_link;
    logic [7:0]   new_vtg;
    logic [7:0]   new_pre;
    sink_status_t status;
    logic         limits_vld, eq_start, status_vld, ctrl_ack, ctrl_native_failed;
    logic         err_chk_failed, ctr_fire;
    logic [7:0]   aux_data;
    logic         aux_vld;
    logic [19:0]  aux_addr;
    logic [7:0]   aux_len;
    aux_cmd_e     aux_cmd;
    tps_e         phy_instruct;
    logic         phy_instruct_vld, ctr_start, cr_failed, start_cr_err, start_eq_err;
    logic [3:0]   err_cr_dn;
    logic         lt_pass, lt_fail;
    link_cfg_t    final_link, adj_link;

    sink_limits_t lim;                 // model copy of the sink limits
    logic [19:0]  burst_addr;
    logic [7:0]   burst_len;
    aux_cmd_e     burst_cmd;
    logic [7:0]   burst_data [0:7];
    int           burst_n;
    int           cycles = 0;
    int           n_pass = 0;
    int           n_fail = 0;
    int           n_cr_err = 0;
    int           n_eq_err = 0;
    link_cfg_t    pass_link;
    logic [3:0]   cr_dn_seen;

    lt_eq_top dut (.*);

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout, the trainings did not finish within %0d cycles", CYCLE_LIMIT);
            $display("** FAIL **");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic check_eq(input string name, input logic [39:0] got, input logic [39:0] exp);
        if (got !== exp)
        begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            $display("** FAIL **");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // pulse monitor, sampled away from the active edge
    always @(negedge clk)
    begin
        if (lt_pass)
        begin
            n_pass++;
            pass_link = final_link;
        end
        if (lt_fail)
            n_fail++;
        if (start_eq_err)
            n_eq_err++;
        if (start_cr_err)
        begin
            n_cr_err++;
            cr_dn_seen = err_cr_dn;
            check_eq("cr_failed", cr_failed, 1'b1);
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // ==================================================================
    // reference rules
    // ==================================================================
    function automatic logic [3:0] mask_of(input lane_cnt_e lc);
        return (lc == LC_1) ? 4'h1 : ((lc == LC_2) ? 4'h3 : 4'hF);
    endfunction

    function automatic logic [7:0] adj_of(input logic [7:0] vtg, input logic [7:0] pre,
                                          input int lane);
        logic [7:0] b;
        b      = 8'h00;
        b[1:0] = vtg[2*lane +: 2];
        b[2]   = (vtg[2*lane +: 2] == lim.max_vtg);
        b[4:3] = pre[2*lane +: 2];
        b[5]   = (pre[2*lane +: 2] == lim.max_pre);
        return b;
    endfunction

    function automatic logic [7:0] tps_code_of(input tps_e t);
        case (t)
            TPS2:    return `LT_TPS2_CODE;
            TPS3:    return `LT_TPS3_CODE;
            TPS4:    return `LT_TPS4_CODE;
            default: return 8'h00;
        endcase
    endfunction

    function automatic bit cr_done_model(input sink_status_t s, input logic [3:0] m);
        return (s.cr_done & m) == m;
    endfunction

    function automatic bit eq_done_model(input sink_status_t s, input logic [3:0] m);
        return cr_done_model(s, m) && ((s.chan_eq & m) == m) && ((s.sym_lock & m) == m) &&
               (s.lane_align == 8'hFF);
    endfunction

    // kind 0 full, 1 eq incomplete, 2 cr incomplete
    function automatic sink_status_t make_status(input int kind, input logic [3:0] m,
                                                 input int nl);
        logic [63:0]  r;
        sink_status_t s;
        r = {$urandom, $urandom};
        s = r[35:0];
        if (kind == 0)
        begin
            s.cr_done    = s.cr_done | m;
            s.chan_eq    = s.chan_eq | m;
            s.sym_lock   = s.sym_lock | m;
            s.lane_align = 8'hFF;
        end
        else if (kind == 1)
        begin
            s.cr_done    = s.cr_done | m;
            s.lane_align = s.lane_align & ~(8'h01 << ($urandom % 8));
        end
        else
            s.cr_done[$urandom % nl] = 1'b0;
        return s;
    endfunction

    // ==================================================================
    // sink side of the aux channel
    // ==================================================================
    task automatic capture_burst();
        burst_n = 0;
        while (!aux_vld)
            step();
        burst_addr = aux_addr;
        burst_len  = aux_len;
        burst_cmd  = aux_cmd;
        while (aux_vld && burst_n < 8)
        begin
            check_eq("aux_addr", aux_addr, burst_addr);   // held through the burst
            check_eq("aux_len", aux_len, burst_len);
            burst_data[burst_n] = aux_data;
            burst_n++;
            step();
        end
    endtask

    task automatic expect_request(input logic [19:0] addr, input logic [7:0] len,
                                  input aux_cmd_e cmd, input int n, input logic [39:0] payload);
        capture_burst();
        check_eq("aux_addr", burst_addr, addr);
        check_eq("aux_len", burst_len, len);
        check_eq("aux_cmd", burst_cmd, cmd);
        check_eq("aux_vld cycles", burst_n, n);
        for (int i = 0; i < n; i++)
            check_eq("aux_data", burst_data[i], payload[39-8*i -: 8]);
    endtask

    task automatic sink_reply(input bit native, input bit with_status, input sink_status_t st);
        repeat (2 + $urandom % 4)
            step();
        ctrl_ack           = !native;
        ctrl_native_failed = native;
        status_vld         = with_status;
        if (with_status)
            status = st;
        step();
        ctrl_ack           = 1'b0;
        ctrl_native_failed = 1'b0;
        status_vld         = 1'b0;
    endtask

    task automatic expect_quiet(input int n);
        repeat (n)
        begin
            step();
            check_eq("aux_vld", aux_vld, 1'b0);
        end
    endtask

    // ==================================================================
    // one training: aborted start, retry, then loops until an outcome
    // ==================================================================
    task automatic run_training();
        link_cfg_t    lnk;
        logic [31:0]  r;
        logic [7:0]   vtg;
        logic [7:0]   pre;
        logic [3:0]   m;
        logic [39:0]  tps_pl;
        sink_status_t st;
        int           nl, mode, k, loops, p0, c0, e0;
        bit           done;
        r = $urandom;
        case (r % 3)
            0:       lim.tps = TPS2;
            1:       lim.tps = TPS3;
            default: lim.tps = TPS4;
        endcase
        lim.max_vtg = r[5:4];
        lim.max_pre = r[7:6];
        lnk.bw      = r[15:8];
        case (r[17:16] % 3)
            0:       lnk.lc = LC_1;
            1:       lnk.lc = LC_2;
            default: lnk.lc = LC_4;
        endcase
        vtg        = r[31:24];
        pre        = $urandom;
        m          = mask_of(lnk.lc);
        nl         = (lnk.lc == LC_1) ? 1 : ((lnk.lc == LC_2) ? 2 : 4);
        tps_pl     = {tps_code_of(lim.tps), adj_of(vtg, pre, 0), adj_of(vtg, pre, 1),
                      adj_of(vtg, pre, 2), adj_of(vtg, pre, 3)};
        mode       = $urandom % 3;         // 0 pass, 1 cr fall-back, 2 eq fall-back
        k          = (mode == 2) ? `LT_MAX_LOOPS : ($urandom % 6);
        limits     = lim;
        limits_vld = 1'b1;
        step();
        limits_vld = 1'b0;
        new_link   = lnk;
        new_vtg    = vtg;
        new_pre    = pre;
        p0         = n_pass;
        c0         = n_cr_err;
        e0         = n_eq_err;

        // first attempt ends with native failed, trainer must go quiet
        eq_start = 1'b1;
        step();
        eq_start = 1'b0;
        expect_request(`LT_ADDR_TPS, nl, AUX_WRITE, nl + 1, tps_pl);
        sink_reply(1'b1, 1'b0, status);
        expect_quiet(6);

        eq_start = 1'b1;
        step();
        eq_start = 1'b0;
        expect_request(`LT_ADDR_TPS, nl, AUX_WRITE, nl + 1, tps_pl);
        check_eq("phy_instruct_vld", phy_instruct_vld, 1'b1);
        check_eq("phy_instruct", phy_instruct, lim.tps);
        check_eq("adj_link", adj_link, lnk);
        sink_reply(1'b0, 1'b0, status);

        loops = 0;
        done  = 1'b0;
        while (!done)
        begin
            while (!ctr_start)
                step();
            repeat ($urandom % 4)
                step();
            ctr_fire = 1'b1;
            step();
            ctr_fire = 1'b0;
            check_eq("ctr_start", ctr_start, 1'b0);
            expect_request(`LT_ADDR_STATUS, `LT_STATUS_LEN, AUX_READ, 1, 40'h0);
            st = make_status((loops < k) ? 1 : ((mode == 0) ? 0 : 2), m, nl);
            sink_reply(1'b0, 1'b1, st);
            if (!cr_done_model(st, m))
            begin
                expect_quiet(6);
                check_eq("start_cr_err count", n_cr_err, c0 + 1);
                check_eq("err_cr_dn", cr_dn_seen, st.cr_done);
                check_eq("lt_pass count", n_pass, p0);
                done = 1'b1;
            end
            else if (eq_done_model(st, m))
            begin
                expect_request(`LT_ADDR_TPS, 8'd0, AUX_WRITE, 1, 40'h0);
                sink_reply(1'b0, 1'b0, status);
                repeat (2)
                    step();
                check_eq("lt_pass count", n_pass, p0 + 1);
                check_eq("final_link", pass_link, lnk);
                done = 1'b1;
            end
            else
            begin
                loops++;
                if (loops == `LT_MAX_LOOPS)
                begin
                    expect_quiet(6);
                    check_eq("start_eq_err count", n_eq_err, e0 + 1);
                    check_eq("lt_pass count", n_pass, p0);
                    done = 1'b1;
                end
                else
                begin
                    expect_request(`LT_ADDR_ADJ, nl - 1, AUX_WRITE, nl,
                                   {adj_of(st.vtg, st.pre, 0), adj_of(st.vtg, st.pre, 1),
                                    adj_of(st.vtg, st.pre, 2), adj_of(st.vtg, st.pre, 3),
                                    8'h00});
                    sink_reply(1'b0, 1'b0, status);
                end
            end
        end
    endtask

    task automatic run_forced_fail();
        int f0;
        f0             = n_fail;
        err_chk_failed = 1'b1;
        step();
        err_chk_failed = 1'b0;
        expect_request(`LT_ADDR_TPS, 8'd0, AUX_WRITE, 1, 40'h0);
        sink_reply(1'b0, 1'b0, status);
        repeat (2)
            step();
        check_eq("lt_fail count", n_fail, f0 + 1);
    endtask

    initial
    begin
        void'($urandom(32'hc693b330));
        rst_n              = 1'b0;
        limits             = '0;
        limits_vld         = 1'b0;
        eq_start           = 1'b0;
        new_link           = '0;
        new_vtg            = 8'h00;
        new_pre            = 8'h00;
        status             = '0;
        status_vld         = 1'b0;
        ctrl_ack           = 1'b0;
        ctrl_native_failed = 1'b0;
        err_chk_failed     = 1'b0;
        ctr_fire           = 1'b0;
        repeat (2)
            @(posedge clk);
        #1;
        rst_n = 1'b1;
        step();
        for (int t = 0; t < NUM_TRAININGS; t++)
        begin
            run_training();
            if ($urandom % 4 == 0)
                run_forced_fail();
        end
        $display("** PASS **");
        $finish;
    end

endmodule
